// ==== rtl/spm_axis_sum.sv ====
`timescale 1ns/1ns

module spm_axis_sum
(
    input  logic            a_clk,
    input  logic            arst_n,
    input  logic            advance,
    input  logic            r_valid,
    input  spm_pkg::wide_t  r_x,
    input  spm_pkg::wide_t  r_y,
    input  spm_pkg::coord_t zs,
    input  spm_pkg::coord_t z_servo,
    input  spm_pkg::coord_t u,
    input  spm_pkg::coord_t z0_cur,
    input  spm_pkg::coord_t u0,
    input  spm_pkg::coord_t slope_x_cur,
    input  spm_pkg::coord_t slope_y_cur,
    input  spm_pkg::coord_t mod_z,
    input  spm_pkg::coord_t mod_u,
    output logic            out_valid,
    output spm_pkg::coord_t out_x,
    output spm_pkg::coord_t out_y,
    output spm_pkg::coord_t out_z,
    output spm_pkg::coord_t out_u
);
    import spm_pkg::*;

    // Clamp to +/- coord_max
    // 40 bits cover the Z sum with slope
    function automatic coord_t sat32(input logic signed [39:0] v);
        if (v > coord_max)
            return coord_max;
        else if (v < -coord_max)
            return -coord_max;
        else
            return coord_t'(v);
    endfunction

    wide_t  zb_2, zb_3;     // Delayed zs + z_servo + z0
    coord_t u_2, u_3;       // Delayed bias input
    coord_t slx_2, slx_3;   // Slopes after k steps
    coord_t sly_2, sly_3;

    logic signed [65:0] dzx_4; // Stage 4 slope products
    logic signed [65:0] dzy_4;
    wide_t              zp_4;  // Z without slope
    wide_t              up_4;  // U sum
    wide_t              x_4;
    wide_t              y_4;
    logic               s_valid;

    logic signed [39:0] z_slope;
    logic signed [39:0] z_total;

    assign z_slope = 40'(dzx_4 >>> q_slope) + 40'(dzy_4 >>> q_slope);
    assign z_total = 40'(zp_4) + z_slope;

    ////////////////////
    // Delay and stage 4
    ////////////////////

    always_ff @(posedge a_clk)
    begin
        if (advance)
        begin
            zb_2  <= wide_t'(zs) + wide_t'(z_servo) + wide_t'(z0_cur); // Stage 2
            u_2   <= u;
            slx_2 <= slope_x_cur;
            sly_2 <= slope_y_cur;
            zb_3  <= zb_2;                                             // Stage 3
            u_3   <= u_2;
            slx_3 <= slx_2;
            sly_3 <= sly_2;
            dzx_4 <= slx_3 * r_x; // Plane in global XY
            dzy_4 <= sly_3 * r_y;
            zp_4  <= zb_3 + wide_t'(mod_z);
            up_4  <= wide_t'(u0) + wide_t'(u_3) + wide_t'(mod_u);
            x_4   <= r_x;
            y_4   <= r_y;
        end
    end

    ////////////////////
    // Output register
    ////////////////////

    always_ff @(posedge a_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            s_valid   <= 1'b0;
            out_valid <= 1'b0;
            out_x     <= '0;
            out_y     <= '0;
            out_z     <= '0;
            out_u     <= '0;
        end
        else if (advance)
        begin
            s_valid   <= r_valid;
            out_valid <= s_valid;
            out_x     <= sat32(40'(x_4));
            out_y     <= sat32(40'(y_4));
            out_z     <= sat32(z_total);
            out_u     <= sat32(40'(up_4));
        end
    end

    // Held result while the sink stalls
    a_stall_hold: assert property (@(posedge a_clk) disable iff (!arst_n)
        !advance |=> out_valid && $stable(out_x) && $stable(out_y) &&
                     $stable(out_z) && $stable(out_u));

endmodule

// ==== rtl/spm_lockin_mod.sv ====
`timescale 1ns/1ns

module spm_lockin_mod
(
    input  logic                 a_clk,
    input  logic                 arst_n,
    input  logic                 advance,
    input  spm_pkg::sc_t         d_sin,
    input  spm_pkg::coord_t      mod_volume,
    input  spm_pkg::mod_target_e mod_target,
    output spm_pkg::coord_t      mod_x,
    output spm_pkg::coord_t      mod_y,
    output spm_pkg::coord_t      mod_z,
    output spm_pkg::coord_t      mod_u
);
    import spm_pkg::*;

    logic signed [56:0] prod_full; // Q31 x 25Q24
    coord_t             prod_2;    // Stage 2, back to Q31
    coord_t             prod_3;    // Stage 3 copy for the Z/U route

    assign prod_full = mod_volume * d_sin;

    always_ff @(posedge a_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            prod_2 <= '0;
            prod_3 <= '0;
        end
        else if (advance)
        begin
            prod_2 <= coord_t'(prod_full >>> q_sc); // Arithmetic, sign kept
            prod_3 <= prod_2;
        end
    end

    // X and Y tap stage 2, Z and U tap stage 3
    assign mod_x = (mod_target == spm_pkg::mod_x) ? prod_2 : '0;
    assign mod_y = (mod_target == spm_pkg::mod_y) ? prod_2 : '0;
    assign mod_z = (mod_target == spm_pkg::mod_z) ? prod_3 : '0;
    assign mod_u = (mod_target == spm_pkg::mod_u) ? prod_3 : '0;

endmodule

// ==== rtl/spm_offset_slew.sv ====
`timescale 1ns/1ns

module spm_offset_slew
(
    input  logic            a_clk,
    input  logic            arst_n,
    input  logic            accept,
    input  spm_pkg::coord_t x0,
    input  spm_pkg::coord_t y0,
    input  spm_pkg::coord_t z0,
    input  spm_pkg::coord_t slope_x,
    input  spm_pkg::coord_t slope_y,
    input  spm_pkg::coord_t xy_step,
    input  spm_pkg::coord_t z_step,
    output spm_pkg::coord_t x0_cur,
    output spm_pkg::coord_t y0_cur,
    output spm_pkg::coord_t z0_cur,
    output spm_pkg::coord_t slope_x_cur,
    output spm_pkg::coord_t slope_y_cur
);
    import spm_pkg::*;

    // One step toward target
    // Guard bit keeps cur +/- step from wrapping
    function automatic coord_t slew_next(input coord_t cur, input coord_t target,
                                         input coord_t step);
        logic signed [32:0] plus;
        logic signed [32:0] minus;
        logic signed [32:0] tgt;
        plus  = {cur[31], cur} + {step[31], step};
        minus = {cur[31], cur} - {step[31], step};
        tgt   = {target[31], target};
        if (tgt > plus)
            return coord_t'(plus);  // Still far above
        else if (tgt < minus)
            return coord_t'(minus); // Still far below
        else
            return target;          // Snap when within one step
    endfunction

    // Difference bounded by step in both directions
    function automatic logic within_step(input coord_t now_v, input coord_t was_v,
                                         input coord_t step);
        logic signed [32:0] diff;
        logic signed [32:0] lim;
        diff = {now_v[31], now_v} - {was_v[31], was_v};
        lim  = {step[31], step};
        return (diff <= lim) && (diff >= -lim);
    endfunction

    always_ff @(posedge a_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            x0_cur      <= '0;
            y0_cur      <= '0;
            z0_cur      <= '0;
            slope_x_cur <= '0;
            slope_y_cur <= '0;
        end
        else if (accept)
        begin
            x0_cur      <= slew_next(x0_cur, x0, xy_step);
            y0_cur      <= slew_next(y0_cur, y0, xy_step);
            z0_cur      <= slew_next(z0_cur, z0, z_step);      // Z0 shares z_step
            slope_x_cur <= slew_next(slope_x_cur, slope_x, z_step);
            slope_y_cur <= slew_next(slope_y_cur, slope_y, z_step);
        end
    end

    // Rate limit per accepted sample
    a_xy_rate: assert property (@(posedge a_clk) disable iff (!arst_n)
        accept |=> within_step(x0_cur, $past(x0_cur), $past(xy_step)) &&
                   within_step(y0_cur, $past(y0_cur), $past(xy_step)));
    a_z_rate: assert property (@(posedge a_clk) disable iff (!arst_n)
        accept |=> within_step(z0_cur, $past(z0_cur), $past(z_step)));

endmodule

// ==== rtl/spm_pkg.sv ====
package spm_pkg;

    ////////////////////
    // Data widths
    ////////////////////

    // Position or value, Q31 full scale
    typedef logic signed [31:0] coord_t;

    // Sum before saturation, room for a few addends
    typedef logic signed [33:0] wide_t;

    // Lock-in sine in 25Q24
    typedef logic signed [24:0] sc_t;

    ////////////////////
    // Q positions
    ////////////////////

    localparam int q_rot   = 28; // Rotation cos/sin in SQ28
    localparam int q_slope = 31; // Plane slope coefficients
    localparam int q_sc    = 24; // Lock-in sine fraction bits

    // Symmetric clamp level for every output axis
    localparam coord_t coord_max = 32'sh7fff_ffff;

    ////////////////////
    // Modulation target
    ////////////////////

    // Codes 5..7 fall through to no modulation
    typedef enum logic [2:0]
    {
        mod_none = 3'd0,
        mod_x    = 3'd1,
        mod_y    = 3'd2,
        mod_z    = 3'd3,
        mod_u    = 3'd4
    } mod_target_e;

endpackage

// ==== rtl/spm_sample_decode.sv ====
`timescale 1ns/1ns

module spm_sample_decode
(
    input  logic            a_clk,
    input  logic            arst_n,
    input  logic            in_valid,
    input  spm_pkg::coord_t xs,
    input  spm_pkg::coord_t ys,
    input  spm_pkg::coord_t zs,
    input  spm_pkg::coord_t z_servo,
    input  spm_pkg::coord_t u,
    input  spm_pkg::sc_t    sc_sin,
    input  logic            out_valid,
    input  logic            out_ready,
    output logic            in_ready,
    output logic            advance,
    output logic            accept,
    output logic            d_valid,
    output spm_pkg::coord_t d_xs,
    output spm_pkg::coord_t d_ys,
    output spm_pkg::coord_t d_zs,
    output spm_pkg::coord_t d_z_servo,
    output spm_pkg::coord_t d_u,
    output spm_pkg::sc_t    d_sin
);

    // Whole pipeline moves unless the output slot is full and held
    assign advance  = !out_valid || out_ready;
    assign in_ready = advance;
    assign accept   = in_valid && advance; // One accepted sample is one update step

    // Stage 1 valid
    always_ff @(posedge a_clk or negedge arst_n)
    begin
        if (!arst_n)
            d_valid <= 1'b0;
        else if (advance)
            d_valid <= in_valid;
    end

    // Stage 1 sample fields
    always_ff @(posedge a_clk)
    begin
        if (advance)
        begin
            d_xs      <= xs;
            d_ys      <= ys;
            d_zs      <= zs;      // Scan Z component
            d_z_servo <= z_servo; // Feedback servo
            d_u       <= u;
            d_sin     <= sc_sin;  // Cosine half not carried
        end
    end

    // Accept only on a moving pipeline, and the sample lands in stage 1
    a_accept_lands: assert property (@(posedge a_clk) disable iff (!arst_n)
        accept |-> advance ##1 d_valid);

endmodule

// ==== rtl/spm_scan_control.sv ====
`timescale 1ns/1ns

module spm_scan_control
(
    input  logic                 a_clk,
    input  logic                 arst_n,
    // Sample input
    input  logic                 in_valid,
    output logic                 in_ready,
    input  spm_pkg::coord_t      xs,
    input  spm_pkg::coord_t      ys,
    input  spm_pkg::coord_t      zs,
    input  spm_pkg::coord_t      z_servo,
    input  spm_pkg::coord_t      u,
    input  spm_pkg::sc_t         sc_sin,
    // Settings
    input  spm_pkg::coord_t      rot_cos,
    input  spm_pkg::coord_t      rot_sin,
    input  spm_pkg::coord_t      slope_x,
    input  spm_pkg::coord_t      slope_y,
    input  spm_pkg::coord_t      x0,
    input  spm_pkg::coord_t      y0,
    input  spm_pkg::coord_t      z0,
    input  spm_pkg::coord_t      u0,
    input  spm_pkg::coord_t      xy_step,
    input  spm_pkg::coord_t      z_step,
    input  spm_pkg::coord_t      mod_volume,
    input  spm_pkg::mod_target_e mod_target,
    // Result output
    output logic                 out_valid,
    input  logic                 out_ready,
    output spm_pkg::coord_t      out_x,
    output spm_pkg::coord_t      out_y,
    output spm_pkg::coord_t      out_z,
    output spm_pkg::coord_t      out_u,
    // Monitors
    output spm_pkg::coord_t      x0_mon,
    output spm_pkg::coord_t      y0_mon,
    output spm_pkg::coord_t      z0_mon
);
    import spm_pkg::*;

    logic   advance;
    logic   accept;
    logic   d_valid;
    coord_t d_xs, d_ys, d_zs, d_z_servo, d_u;
    sc_t    d_sin;
    coord_t slope_x_cur, slope_y_cur;
    coord_t mod_x, mod_y, mod_z, mod_u;
    logic   r_valid;
    wide_t  r_x, r_y;

    // Decode
    spm_sample_decode i_decode (
        .a_clk(a_clk), .arst_n(arst_n), .in_valid(in_valid),
        .xs(xs), .ys(ys), .zs(zs), .z_servo(z_servo), .u(u), .sc_sin(sc_sin),
        .out_valid(out_valid), .out_ready(out_ready),
        .in_ready(in_ready), .advance(advance), .accept(accept), .d_valid(d_valid),
        .d_xs(d_xs), .d_ys(d_ys), .d_zs(d_zs), .d_z_servo(d_z_servo), .d_u(d_u),
        .d_sin(d_sin)
    );

    // Execute
    spm_offset_slew i_slew (
        .a_clk(a_clk), .arst_n(arst_n), .accept(accept),
        .x0(x0), .y0(y0), .z0(z0), .slope_x(slope_x), .slope_y(slope_y),
        .xy_step(xy_step), .z_step(z_step),
        .x0_cur(x0_mon), .y0_cur(y0_mon), .z0_cur(z0_mon), // Monitors are the live offsets
        .slope_x_cur(slope_x_cur), .slope_y_cur(slope_y_cur)
    );

    spm_lockin_mod i_lockin (
        .a_clk(a_clk), .arst_n(arst_n), .advance(advance), .d_sin(d_sin),
        .mod_volume(mod_volume), .mod_target(mod_target),
        .mod_x(mod_x), .mod_y(mod_y), .mod_z(mod_z), .mod_u(mod_u)
    );

    spm_scan_rotate i_rotate (
        .a_clk(a_clk), .arst_n(arst_n), .advance(advance), .d_valid(d_valid),
        .d_xs(d_xs), .d_ys(d_ys), .rot_cos(rot_cos), .rot_sin(rot_sin),
        .x0_cur(x0_mon), .y0_cur(y0_mon), .mod_x(mod_x), .mod_y(mod_y),
        .r_valid(r_valid), .r_x(r_x), .r_y(r_y)
    );

    // Result
    spm_axis_sum i_sum (
        .a_clk(a_clk), .arst_n(arst_n), .advance(advance), .r_valid(r_valid),
        .r_x(r_x), .r_y(r_y), .zs(d_zs), .z_servo(d_z_servo), .u(d_u),
        .z0_cur(z0_mon), .u0(u0), .slope_x_cur(slope_x_cur), .slope_y_cur(slope_y_cur),
        .mod_z(mod_z), .mod_u(mod_u), .out_valid(out_valid),
        .out_x(out_x), .out_y(out_y), .out_z(out_z), .out_u(out_u)
    );

endmodule

// ==== rtl/spm_scan_rotate.sv ====
`timescale 1ns/1ns

module spm_scan_rotate
(
    input  logic            a_clk,
    input  logic            arst_n,
    input  logic            advance,
    input  logic            d_valid,
    input  spm_pkg::coord_t d_xs,
    input  spm_pkg::coord_t d_ys,
    input  spm_pkg::coord_t rot_cos,
    input  spm_pkg::coord_t rot_sin,
    input  spm_pkg::coord_t x0_cur,
    input  spm_pkg::coord_t y0_cur,
    input  spm_pkg::coord_t mod_x,
    input  spm_pkg::coord_t mod_y,
    output logic            r_valid,
    output spm_pkg::wide_t  r_x,
    output spm_pkg::wide_t  r_y
);
    import spm_pkg::*;

    // Xr =  cos*xs + sin*ys
    // Yr = -sin*xs + cos*ys
    logic signed [64:0] rot_x_c;
    logic signed [64:0] rot_y_c;

    logic signed [64:0] rot_x_p; // Stage 2 product sums
    logic signed [64:0] rot_y_p;
    coord_t             x0_p;    // Offsets after k steps
    coord_t             y0_p;
    logic               p_valid;

    assign rot_x_c = rot_cos * d_xs + rot_sin * d_ys;
    assign rot_y_c = rot_cos * d_ys - rot_sin * d_xs;

    ////////////////////
    // Stage valids
    ////////////////////

    always_ff @(posedge a_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            p_valid <= 1'b0;
            r_valid <= 1'b0;
        end
        else if (advance)
        begin
            p_valid <= d_valid;
            r_valid <= p_valid;
        end
    end

    ////////////////////
    // Datapath
    ////////////////////

    always_ff @(posedge a_clk)
    begin
        if (advance)
        begin
            // Stage 2
            rot_x_p <= rot_x_c;
            rot_y_p <= rot_y_c;
            x0_p    <= x0_cur; // Captured before the next accept steps it
            y0_p    <= y0_cur;

            // Stage 3, global position at 34 bits
            r_x <= wide_t'(rot_x_p >>> q_rot) + wide_t'(x0_p) + wide_t'(mod_x);
            r_y <= wide_t'(rot_y_p >>> q_rot) + wide_t'(y0_p) + wide_t'(mod_y);
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --timing --assert \
    --top-module spm_scan_control_tb \
    -f spm_scan_control.f \
    --Mdir obj_dir -o spm_scan_control_sim

./obj_dir/spm_scan_control_sim | tee sim.log || true

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

// ==== spm_scan_control.f ====
rtl/spm_pkg.sv
rtl/spm_sample_decode.sv
rtl/spm_offset_slew.sv
rtl/spm_lockin_mod.sv
rtl/spm_scan_rotate.sv
rtl/spm_axis_sum.sv
rtl/spm_scan_control.sv
testbench/spm_scan_control_tb.sv

// ==== testbench/spm_scan_control_tb.sv ====
`timescale 1ns/1ns

module spm_scan_control_tb;
    import spm_pkg::*;

    localparam coord_t one = 32'sh1000_0000; // 1.0 in SQ28
    localparam coord_t c8  = 32'sd214748365; // 0.8
    localparam coord_t s6  = 32'sd161061274; // 0.6
    localparam coord_t big = 32'sh7fff_ffff;

    typedef struct {
        string      name;
        coord_t     cs, sn, xs, ys, zs, zsv, u;
        sc_t        sc;
        coord_t     x0, y0, z0, u0, slx, sly, xys, zst, vol;
        logic [2:0] tgt;
        int         n;
        bit         bp;
    } row_t;

    logic a_clk = 1'b0;
    logic arst_n = 1'b0;
    logic in_valid, in_ready, out_valid, out_ready;
    coord_t xs, ys, zs, z_servo, u;
    sc_t sc_sin;
    coord_t rot_cos, rot_sin, slope_x, slope_y, x0, y0, z0, u0, xy_step, z_step, mod_volume;
    logic [2:0] mod_target;
    coord_t out_x, out_y, out_z, out_u, x0_mon, y0_mon, z0_mon;

    row_t   rows[$];
    coord_t exp_x[$], exp_y[$], exp_z[$], exp_u[$];
    string  exp_name[$];
    int     exp_cyc[$];   // Presentation cycle or -1 where stalls are allowed
    string  cur_name;
    bit     cur_bp;
    bit     bp_mode = 1'b0;
    bit     mon_pending = 1'b0;
    int     cyc = 0;
    int     limit = 100000;
    coord_t m_x0 = '0, m_y0 = '0, m_z0 = '0, m_slx = '0, m_sly = '0; // Model offsets

    spm_scan_control i_dut (
        .a_clk(a_clk), .arst_n(arst_n), .in_valid(in_valid), .in_ready(in_ready),
        .xs(xs), .ys(ys), .zs(zs), .z_servo(z_servo), .u(u), .sc_sin(sc_sin),
        .rot_cos(rot_cos), .rot_sin(rot_sin), .slope_x(slope_x), .slope_y(slope_y),
        .x0(x0), .y0(y0), .z0(z0), .u0(u0), .xy_step(xy_step), .z_step(z_step),
        .mod_volume(mod_volume), .mod_target(mod_target_e'(mod_target)),
        .out_valid(out_valid), .out_ready(out_ready),
        .out_x(out_x), .out_y(out_y), .out_z(out_z), .out_u(out_u),
        .x0_mon(x0_mon), .y0_mon(y0_mon), .z0_mon(z0_mon)
    );

    always #4 a_clk = ~a_clk; // 8 ns period

    ////////////////////
    // Checks and model
    ////////////////////

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("** Error %s: expected %h, actual %h", what, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    // Move toward target by at most one step and snap when close
    function automatic coord_t slew_step(input coord_t cur, input coord_t tgt,
                                         input coord_t step);
        longint c;
        longint t;
        longint s;
        c = cur;
        t = tgt;
        s = step;
        if (t > c + s)
            return coord_t'(c + s);
        else if (t < c - s)
            return coord_t'(c - s);
        return tgt;
    endfunction

    function automatic coord_t clamp(input logic signed [39:0] v);
        if (v > 40'sh00_7fff_ffff)
            return big;
        else if (v < -40'sh00_7fff_ffff)
            return -big;
        return coord_t'(v);
    endfunction

    // Model of one accepted sample with the offsets after its step
    task automatic predict();
        logic signed [64:0] rx_full;
        logic signed [64:0] ry_full;
        logic signed [33:0] rx;
        logic signed [33:0] ry;
        logic signed [33:0] up;
        logic signed [65:0] px;
        logic signed [65:0] py;
        logic signed [39:0] zt;
        coord_t prod;
        coord_t mx, my, mz, mu;
        m_x0  = slew_step(m_x0, x0, xy_step);
        m_y0  = slew_step(m_y0, y0, xy_step);
        m_z0  = slew_step(m_z0, z0, z_step);
        m_slx = slew_step(m_slx, slope_x, z_step);
        m_sly = slew_step(m_sly, slope_y, z_step);
        prod = coord_t'((longint'(mod_volume) * longint'(sc_sin)) >>> 24);
        mx = (mod_target == 3'd1) ? prod : '0; // Only one axis gets it
        my = (mod_target == 3'd2) ? prod : '0;
        mz = (mod_target == 3'd3) ? prod : '0;
        mu = (mod_target == 3'd4) ? prod : '0;
        rx_full = rot_cos * xs + rot_sin * ys;
        ry_full = rot_cos * ys - rot_sin * xs;
        rx = 34'(rx_full >>> 28) + m_x0 + mx;
        ry = 34'(ry_full >>> 28) + m_y0 + my;
        px = m_slx * rx;   // Plane term in global XY
        py = m_sly * ry;
        zt = 40'(px >>> 31) + 40'(py >>> 31) + zs + z_servo + m_z0 + mz;
        up = u0 + u + mu;
        exp_x.push_back(clamp(40'(rx)));
        exp_y.push_back(clamp(40'(ry)));
        exp_z.push_back(clamp(zt));
        exp_u.push_back(clamp(40'(up)));
        exp_name.push_back(cur_name);
        exp_cyc.push_back(cur_bp ? -1 : cyc);
    endtask

    ////////////////////
    // Observation
    ////////////////////

    always @(negedge a_clk)
    begin
        string nm;
        int    pc;
        if (arst_n)
        begin
            if (out_valid && out_ready)
            begin
                if (exp_x.size() == 0)
                begin
                    $display("Result delivered with no sample outstanding");
                    $display("SOME TESTS FAILED");
                    $fatal(1, "Extra output");
                end
                nm = exp_name.pop_front();
                pc = exp_cyc.pop_front();
                check_value({nm, " out_x"}, exp_x.pop_front(), out_x);
                check_value({nm, " out_y"}, exp_y.pop_front(), out_y);
                check_value({nm, " out_z"}, exp_z.pop_front(), out_z);
                check_value({nm, " out_u"}, exp_u.pop_front(), out_u);
                if (pc >= 0)
                    check_value({nm, " latency"}, pc + 5, cyc); // Five register stages
            end
            if (mon_pending)
            begin
                check_value({cur_name, " x0_mon"}, m_x0, x0_mon);
                check_value({cur_name, " y0_mon"}, m_y0, y0_mon);
                check_value({cur_name, " z0_mon"}, m_z0, z0_mon);
                mon_pending = 1'b0;
            end
            if (in_valid && in_ready)
            begin
                predict();
                mon_pending = 1'b1; // Offsets stepped on the coming edge
            end
        end
    end

    // Sink stalls in back-pressure rows
    always @(posedge a_clk)
    begin
        if (bp_mode)
            out_ready <= ($urandom % 3) != 0;
        else
            out_ready <= 1'b1;
    end

    always @(posedge a_clk)
    begin
        cyc <= cyc + 1;
        if (cyc > limit)
        begin
            $display("Timeout, the run went past %0d cycles", limit);
            $display("SOME TESTS FAILED");
            $fatal(1, "Timeout");
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic add_row(input string name, input coord_t cs, sn, xs_v, ys_v, zs_v,
                           zsv_v, u_v, input sc_t sc, input coord_t x0_v, y0_v, z0_v,
                           u0_v, slx, sly, xys, zst, vol, input logic [2:0] tgt,
                           input int n, input bit bp);
        row_t r;
        r = '{name, cs, sn, xs_v, ys_v, zs_v, zsv_v, u_v, sc, x0_v, y0_v, z0_v,
              u0_v, slx, sly, xys, zst, vol, tgt, n, bp};
        rows.push_back(r);
    endtask

    task automatic run_row(input row_t r);
        bit ok;
        @(posedge a_clk);
        cur_name   = r.name;
        cur_bp     = r.bp;
        bp_mode    <= r.bp;
        rot_cos    <= r.cs;
        rot_sin    <= r.sn;
        x0         <= r.x0;
        y0         <= r.y0;
        z0         <= r.z0;
        u0         <= r.u0;
        slope_x    <= r.slx;
        slope_y    <= r.sly;
        xy_step    <= r.xys;
        z_step     <= r.zst;
        mod_volume <= r.vol;
        mod_target <= r.tgt;
        for (int j = 0; j < r.n; j++)
        begin
            in_valid <= 1'b1;
            xs       <= r.xs ^ (j << 8); // XOR keeps the sign of large values
            ys       <= r.ys ^ (j << 7);
            zs       <= r.zs;
            z_servo  <= r.zsv ^ j;
            u        <= r.u ^ j;
            sc_sin   <= (j % 2) ? -r.sc : r.sc;
            do
            begin
                @(negedge a_clk);
                ok = in_ready;
                @(posedge a_clk);
            end
            while (!ok);
        end
        in_valid <= 1'b0;
        while (exp_x.size() != 0)
            @(posedge a_clk);
        bp_mode <= 1'b0;
    endtask

    initial
    begin
        int unused;
        unused = $urandom(32'hc785);
        in_valid   = 0;
        xs         = 0;
        ys         = 0;
        zs         = 0;
        z_servo    = 0;
        u          = 0;
        sc_sin     = 0;
        rot_cos    = one;
        rot_sin    = 0;
        slope_x    = 0;
        slope_y    = 0;
        x0         = 0;
        y0         = 0;
        z0         = 0;
        u0         = 0;
        xy_step    = 0;
        z_step     = 0;
        mod_volume = 0;
        mod_target = 0;
        out_ready  = 1'b1;
        // name, cos, sin, xs, ys, zs, z_servo, u, sin, x0, y0, z0, u0, slopes, steps, vol
        add_row("identity", one, 0, 'h10000, -'h20000, 0, 0, 'h300, 0, 0, 0, 0, 'h400,
                0, 0, big, big, 0, 0, 3, 0);
        add_row("identity_mix", one, 0, -'h123456, 'h654321, 'h10, 'h20, -'h55, 0, 0, 0, 0,
                -'h99, 0, 0, big, big, 0, 0, 3, 0);
        add_row("rot_90", 0, one, 'h111111, 'h222222, 0, 0, 0, 0, 0, 0, 0, 0,
                0, 0, big, big, 0, 0, 3, 0);
        add_row("rot_mixed", c8, s6, 'h0333333, -'h0777777, 0, 0, 0, 0, 0, 0, 0, 0,
                0, 0, big, big, 0, 0, 3, 0);
        add_row("rot_mixed_neg", -c8, -s6, -'h1234567, 'h0abcdef, 0, 0, 0, 0, 0, 0, 0, 0,
                0, 0, big, big, 0, 0, 3, 0);
        add_row("slew_xy", one, 0, 'h1000, 'h2000, 0, 0, 0, 0, 'h1000, -'h0c00, 0, 0,
                0, 0, 'h100, 'h100, 0, 0, 20, 0);
        add_row("slew_xy_back", one, 0, 'h1000, 'h2000, 0, 0, 0, 0, -'h800, 'h800, 0, 0,
                0, 0, 'h180, 'h100, 0, 0, 14, 0);
        add_row("z_slope", one, 0, 'h100000, -'h80000, 'h1000, 'h2000, 0, 0, 0, 0,
                'h3000_0000, 0, 'h4000_0000, -'h2000_0000, 'h100, 'h1000_0000, 0, 0, 8, 0);
        add_row("z_slope_rot", c8, -s6, -'h300000, 'h500000, -'h4000, 'h100, 0, 0, 0, 0,
                -'h1000_0000, 0, -'h3000_0000, 'h1800_0000, 'h100, 'h0800_0000, 0, 0, 6, 0);
        add_row("sat_pos", one, 0, big, 'h7fff_0000, 'h7000_0000, 'h7000_0000, 'h7000_0000,
                0, 'h7000_0000, 'h7000_0000, 'h7000_0000, 'h7000_0000, 'h7000_0000,
                'h7000_0000, big, big, 0, 0, 3, 0);
        add_row("sat_neg", one, 0, -big, -'h7fff_0000, -'h7000_0000, -'h7000_0000,
                -'h7000_0000, 0, -'h7000_0000, -'h7000_0000, -'h7000_0000, -'h7000_0000,
                'h7000_0000, 'h7000_0000, big, big, 0, 0, 3, 0);
        for (int t = 0; t < 5; t++)
            add_row($sformatf("mod_code_%0d", t), one, 0, 'h40000, 'h50000, 'h100, 'h200,
                    'h300, 'h080_0000, 0, 0, 0, 'h100, 0, 0, big, big, 'h4000_0000,
                    t, 4, 0);
        add_row("mod_code_6", one, 0, 'h40000, 'h50000, 'h100, 'h200, 'h300, 'h0c0_0000,
                0, 0, 0, 'h100, 0, 0, big, big, 'h4000_0000, 6, 4, 0);
        add_row("bp_random", c8, s6, 'h200000, 'h100000, 'h10, 'h20, 'h30, 'h0a0_0000,
                'h1000, 'h2000, 'h3000, 'h40, 'h100_0000, 'h200_0000, 'h100, 'h100_0000,
                'h2000_0000, 3, 24, 1);
        add_row("bp_slew", one, 0, 'h1000, -'h1000, 0, 0, 0, 0, -'h1000, 'h1800, -'h800,
                0, 0, 0, 'h100, 'h100, 0, 0, 20, 1);
        limit = rows.size() * 20 + 100;
        repeat (4) @(posedge a_clk);
        arst_n <= 1'b1;
        @(negedge a_clk);
        check_value("reset in_ready", 1, in_ready);
        check_value("reset out_valid", 0, out_valid);
        check_value("reset x0_mon", 0, x0_mon);
        foreach (rows[i])
            run_row(rows[i]);
        if (exp_x.size() == 0)
        begin
            $display("ALL TESTS PASSED");
            $finish;
        end
        else
        begin
            $display("Samples were accepted but their results never came out");
            $display("SOME TESTS FAILED");
            $fatal(1, "Lost results");
        end
    end

endmodule
